/* include/ntm_macros.svh */
`ifndef NTM_MACROS_SVH
`define NTM_MACROS_SVH

////////////////////////////////////////
// Global sizes
////////////////////////////////////////

// Residue width in bits
`define NTM_DATA_SIZE 16

// Square matrix order, rows equal columns
`define NTM_MATRIX_ORDER 2

`endif

/* verilog/ntm_math_pkg.sv */
`default_nettype none

package ntm_math_pkg;

  `include "ntm_macros.svh"

  // One residue word as carried between blocks
  typedef logic [`NTM_DATA_SIZE-1:0] ntm_word_t;

  // Adder opcode
  typedef enum logic {
    ADD_OP = 1'b0,
    SUB_OP = 1'b1
  } ntm_add_op_t;

  // Operand bundle for a scalar unit, kept stable until READY
  typedef struct packed {
    ntm_word_t modulo;
    ntm_word_t data_a;
    ntm_word_t data_b;
  } ntm_operands_t;

endpackage

`default_nettype wire

/* verilog/ntm_ctrl_pkg.sv */
`default_nettype none

package ntm_ctrl_pkg;

  `include "ntm_macros.svh"

  // Inversion sequence states
  typedef enum logic [3:0] {
    STARTER_ST   = 4'd0,
    LOAD_ST      = 4'd1,
    DET_MUL_ST   = 4'd2,
    DET_SUB_ST   = 4'd3,
    EXP_PREP_ST  = 4'd4,
    EXP_STEP_ST  = 4'd5,
    ADJ_NEG_ST   = 4'd6,
    OUT_MUL_ST   = 4'd7,
    ENDER_ST     = 4'd8
  } ntm_state_t;

  // Row-major element index, also reused as a sub-step counter
  typedef logic [$clog2(`NTM_MATRIX_ORDER*`NTM_MATRIX_ORDER)-1:0] ntm_index_t;

endpackage

`default_nettype wire

/* verilog/ntm_scalar_adder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_scalar_adder
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_add_op_t          OPERATION,
  input  ntm_operands_t        OPERANDS,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  // Operand words at local width
  logic [DATA_SIZE-1:0] op_m;
  logic [DATA_SIZE-1:0] op_a;
  logic [DATA_SIZE-1:0] op_b;

  // One extra bit for carry and borrow
  logic [DATA_SIZE:0]   sum;
  logic [DATA_SIZE:0]   diff;
  logic [DATA_SIZE:0]   result;

  assign op_m = DATA_SIZE'(OPERANDS.modulo);
  assign op_a = DATA_SIZE'(OPERANDS.data_a);
  assign op_b = DATA_SIZE'(OPERANDS.data_b);

  ////////////////////////////////////////
  // Modular add or subtract
  ////////////////////////////////////////

  always_comb begin
    sum  = {1'b0, op_a} + {1'b0, op_b};
    diff = {1'b0, op_a} - {1'b0, op_b};
    case (OPERATION)
      // Single correction is enough, inputs are below m
      ADD_OP:  result = (sum >= {1'b0, op_m}) ? sum - {1'b0, op_m} : sum;
      // Borrow out means a wrap below zero
      SUB_OP:  result = diff[DATA_SIZE] ? diff + {1'b0, op_m} : diff;
      default: result = '0;
    endcase
  end

  // Handshake, one cycle latency
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= result[DATA_SIZE-1:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/ntm_scalar_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_scalar_multiplier
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_operands_t        OPERANDS,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int CNT_SIZE = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;

  logic [DATA_SIZE-1:0] op_m;
  logic [DATA_SIZE-1:0] op_a;
  logic [DATA_SIZE-1:0] op_b;

  // Bit scan control
  logic                 busy_int;
  logic [CNT_SIZE-1:0]  cnt_int;

  // Intermediate residues, one bit wider than the modulus
  logic [DATA_SIZE:0]   dbl;
  logic [DATA_SIZE:0]   sum;

  assign op_m = DATA_SIZE'(OPERANDS.modulo);
  assign op_a = DATA_SIZE'(OPERANDS.data_a);
  assign op_b = DATA_SIZE'(OPERANDS.data_b);

  ////////////////////////////////////////
  // One interleaved step
  ////////////////////////////////////////

  always_comb begin
    // Accumulator doubled, reduced once
    dbl = {DATA_OUT, 1'b0};
    if (dbl >= {1'b0, op_m}) begin
      dbl = dbl - {1'b0, op_m};
    end
    // Add multiplicand on a set bit of data_b
    sum = op_b[cnt_int] ? dbl + {1'b0, op_a} : dbl;
    if (sum >= {1'b0, op_m}) begin
      sum = sum - {1'b0, op_m};
    end
  end

  // Counter runs from the top bit of data_b down to bit 0
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_int <= 1'b0;
      cnt_int  <= '0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (START) begin
        busy_int <= 1'b1;
        cnt_int  <= CNT_SIZE'(DATA_SIZE - 1);
      end else if (busy_int) begin
        if (cnt_int == '0) begin
          busy_int <= 1'b0;
          READY    <= 1'b1;
        end else begin
          cnt_int <= cnt_int - 1'b1;
        end
      end
    end
  end

  // Accumulator, cleared on START
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= '0;
    end else if (busy_int) begin
      DATA_OUT <= sum[DATA_SIZE-1:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/ntm_matrix_inversion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_inversion
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  // Global
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,

  input  logic                 DATA_IN_I_ENABLE,
  input  logic                 DATA_IN_J_ENABLE,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE,

  // Data
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int ORDER    = `NTM_MATRIX_ORDER;
  localparam int ELEMS    = ORDER * ORDER;
  localparam int POS_SIZE = $clog2(ORDER);
  localparam int CNT_SIZE = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  ntm_state_t           state_int;

  // Held modulus and matrix, b and c are negated in place
  logic [DATA_SIZE-1:0] modulo_int;
  logic [DATA_SIZE-1:0] matrix_int [ELEMS];

  // Load position
  logic [POS_SIZE-1:0]  row_int;
  logic [POS_SIZE-1:0]  col_int;
  logic [POS_SIZE-1:0]  wr_row;
  logic [POS_SIZE-1:0]  wr_col;
  ntm_index_t           wr_idx;

  // Sub-step or output index
  ntm_index_t           idx_int;
  ntm_index_t           idx_nxt;

  // Determinant, exponent m-2 and running power
  logic [DATA_SIZE-1:0] prod_int;
  logic [DATA_SIZE-1:0] det_int;
  logic [DATA_SIZE-1:0] exp_int;
  logic [DATA_SIZE-1:0] inv_int;
  logic [CNT_SIZE-1:0]  bit_int;

  // Adder side, every use here is a subtraction
  logic                 start_add;
  logic                 ready_add;
  ntm_operands_t        add_ops;
  logic [DATA_SIZE-1:0] add_out;

  // Multiplier side
  logic                 start_mul;
  logic                 ready_mul;
  ntm_operands_t        mul_ops;
  logic [DATA_SIZE-1:0] mul_out;

  function automatic ntm_operands_t pack_ops(input logic [DATA_SIZE-1:0] m,
                                             input logic [DATA_SIZE-1:0] a,
                                             input logic [DATA_SIZE-1:0] b);
    ntm_operands_t ops;
    ops.modulo = ntm_word_t'(m);
    ops.data_a = ntm_word_t'(a);
    ops.data_b = ntm_word_t'(b);
    return ops;
  endfunction

  // Adjugate source, diagonal swapped
  function automatic ntm_index_t adj_src(input ntm_index_t k);
    return (k[0] == k[1]) ? ~k : k;
  endfunction

  // I strobe restarts the column, moving to a new row if mid-row
  always_comb begin
    wr_col = DATA_IN_I_ENABLE ? '0 : col_int;
    wr_row = (DATA_IN_I_ENABLE && col_int != '0) ? row_int + 1'b1 : row_int;
  end

  assign wr_idx  = ntm_index_t'(wr_row * ORDER + wr_col);
  assign idx_nxt = ntm_index_t'(idx_int + 1'b1);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_int         <= STARTER_ST;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
      start_add         <= 1'b0;
      start_mul         <= 1'b0;
      add_ops           <= '0;
      mul_ops           <= '0;
      modulo_int        <= '0;
      row_int           <= '0;
      col_int           <= '0;
      idx_int           <= '0;
      bit_int           <= '0;
      prod_int          <= '0;
      det_int           <= '0;
      exp_int           <= '0;
      inv_int           <= '0;
      for (int i = 0; i < ELEMS; i++) begin
        matrix_int[i] <= '0;
      end
    end else begin
      // Pulses default low
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      start_add         <= 1'b0;
      start_mul         <= 1'b0;
      case (state_int)
        STARTER_ST: begin
          if (START) begin
            modulo_int <= MODULO_IN;
            row_int    <= '0;
            col_int    <= '0;
            state_int  <= LOAD_ST;
          end
        end
        LOAD_ST: begin
          if (DATA_IN_J_ENABLE) begin
            matrix_int[wr_idx] <= DATA_IN;
            if (wr_col == POS_SIZE'(ORDER - 1)) begin
              col_int <= '0;
              row_int <= wr_row + 1'b1;
            end else begin
              col_int <= wr_col + 1'b1;
              row_int <= wr_row;
            end
            // Last element is d, start a*d at once
            if (wr_idx == ntm_index_t'(ELEMS - 1)) begin
              mul_ops   <= pack_ops(modulo_int, matrix_int[0], DATA_IN);
              start_mul <= 1'b1;
              idx_int   <= '0;
              state_int <= DET_MUL_ST;
            end
          end
        end
        DET_MUL_ST: begin
          if (ready_mul) begin
            if (idx_int == '0) begin
              // a*d kept, now b*c
              prod_int  <= mul_out;
              mul_ops   <= pack_ops(modulo_int, matrix_int[1], matrix_int[2]);
              start_mul <= 1'b1;
              idx_int   <= idx_nxt;
            end else begin
              add_ops   <= pack_ops(modulo_int, prod_int, mul_out);
              start_add <= 1'b1;
              state_int <= DET_SUB_ST;
            end
          end
        end
        DET_SUB_ST: begin
          if (ready_add) begin
            // Exponent m-2 on the adder
            det_int   <= add_out;
            add_ops   <= pack_ops(modulo_int, modulo_int, DATA_SIZE'(2));
            start_add <= 1'b1;
            state_int <= EXP_PREP_ST;
          end
        end
        EXP_PREP_ST: begin
          if (ready_add) begin
            // Power starts at 1, first square is 1*1
            exp_int   <= add_out;
            bit_int   <= CNT_SIZE'(DATA_SIZE - 1);
            idx_int   <= '0;
            mul_ops   <= pack_ops(modulo_int, DATA_SIZE'(1), DATA_SIZE'(1));
            start_mul <= 1'b1;
            state_int <= EXP_STEP_ST;
          end
        end
        EXP_STEP_ST: begin
          // Left to right square and multiply, idx 0 square, idx 1 multiply
          if (ready_mul) begin
            inv_int <= mul_out;
            if (idx_int == '0 && exp_int[bit_int]) begin
              mul_ops   <= pack_ops(modulo_int, mul_out, det_int);
              start_mul <= 1'b1;
              idx_int   <= idx_nxt;
            end else if (bit_int == '0) begin
              // Power done, negate b
              add_ops   <= pack_ops(modulo_int, '0, matrix_int[1]);
              start_add <= 1'b1;
              idx_int   <= '0;
              state_int <= ADJ_NEG_ST;
            end else begin
              bit_int   <= bit_int - 1'b1;
              idx_int   <= '0;
              mul_ops   <= pack_ops(modulo_int, mul_out, mul_out);
              start_mul <= 1'b1;
            end
          end
        end
        ADJ_NEG_ST: begin
          if (ready_add) begin
            if (idx_int == '0) begin
              matrix_int[1] <= add_out;
              add_ops       <= pack_ops(modulo_int, '0, matrix_int[2]);
              start_add     <= 1'b1;
              idx_int       <= idx_nxt;
            end else begin
              // First output is inv*d
              matrix_int[2] <= add_out;
              mul_ops       <= pack_ops(modulo_int, inv_int, matrix_int[adj_src('0)]);
              start_mul     <= 1'b1;
              idx_int       <= '0;
              state_int     <= OUT_MUL_ST;
            end
          end
        end
        OUT_MUL_ST: begin
          if (ready_mul) begin
            // Each product leaves as soon as it is ready
            DATA_OUT          <= mul_out;
            DATA_OUT_J_ENABLE <= 1'b1;
            DATA_OUT_I_ENABLE <= (idx_int % ORDER) == 0;
            if (idx_int == ntm_index_t'(ELEMS - 1)) begin
              state_int <= ENDER_ST;
            end else begin
              mul_ops   <= pack_ops(modulo_int, inv_int, matrix_int[adj_src(idx_nxt)]);
              start_mul <= 1'b1;
              idx_int   <= idx_nxt;
            end
          end
        end
        ENDER_ST: begin
          READY     <= 1'b1;
          state_int <= STARTER_ST;
        end
        default: begin
          state_int <= STARTER_ST;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath units
  ////////////////////////////////////////

  ntm_scalar_adder #(
    .DATA_SIZE(DATA_SIZE)
  ) i_ntm_scalar_adder (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_add),
    .OPERATION(SUB_OP),
    .OPERANDS (add_ops),
    .READY    (ready_add),
    .DATA_OUT (add_out)
  );

  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) i_ntm_scalar_multiplier (
    .CLK     (CLK),
    .RST     (RST),
    .START   (start_mul),
    .OPERANDS(mul_ops),
    .READY   (ready_mul),
    .DATA_OUT(mul_out)
  );

endmodule

`default_nettype wire

/* testbench/ntm_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic RST
);

  // Free running clock, low first
  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Reset over the first rising edges, released away from an edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #(PERIOD_NS / 4);
    RST = 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/ntm_matrix_inversion_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_inversion_chk
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire logic       CLK,
  input  wire logic       RST,
  input  ntm_state_t      state,
  input  wire logic       start_add,
  input  wire logic       ready_add,
  input  wire logic       start_mul,
  input  wire logic       ready_mul,
  input  wire logic       ready,
  input  wire logic       out_i_enable,
  input  wire logic       out_j_enable
);

  // Failed assertions, read back by the testbench
  int fail_count = 0;

  ////////////////////////////////////////
  // Unit latencies
  ////////////////////////////////////////

  adder_latency: assert property (@(posedge CLK) disable iff (RST)
    start_add |=> ready_add)
    else begin
      fail_count++;
      $error("adder READY did not follow START by one cycle");
    end

  mul_latency: assert property (@(posedge CLK) disable iff (RST)
    start_mul |-> ##(DATA_SIZE + 1) ready_mul)
    else begin
      fail_count++;
      $error("multiplier READY did not come DATA_SIZE+1 cycles after START");
    end

  // Busy multiplier is never restarted
  mul_not_busy: assert property (@(posedge CLK) disable iff (RST)
    start_mul |=> !start_mul [*DATA_SIZE + 1])
    else begin
      fail_count++;
      $error("multiplier started again while busy");
    end

  ////////////////////////////////////////
  // Output framing
  ////////////////////////////////////////

  ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else begin
      fail_count++;
      $error("READY held longer than one cycle");
    end

  // Fourth strobe moves to ender, READY next
  ready_after_last: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable && state == ENDER_ST |=> ready)
    else begin
      fail_count++;
      $error("READY did not follow the last output strobe");
    end

  i_with_j: assert property (@(posedge CLK) disable iff (RST)
    out_i_enable |-> out_j_enable)
    else begin
      fail_count++;
      $error("output I strobe without J strobe");
    end

  strobe_state: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable |-> (state == OUT_MUL_ST || state == ENDER_ST))
    else begin
      fail_count++;
      $error("output strobe outside the output phase");
    end

endmodule

`default_nettype wire

/* testbench/ntm_matrix_inversion_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_inversion_tb;

  localparam int DATA_SIZE      = `NTM_DATA_SIZE;
  localparam int ORDER          = `NTM_MATRIX_ORDER;
  localparam int ELEMS          = ORDER * ORDER;
  localparam int DRIVE_DELAY    = 10;
  localparam int NUM_DIRECTED   = 6;
  localparam int NUM_RANDOM     = 32;
  localparam int NUM_PRIMES     = 11;
  // About 700 cycles per matrix at 16 bits, rounded up with margin
  localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM + 2) * 1000;

  typedef logic [ELEMS-1:0][DATA_SIZE-1:0] matrix_t;

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic                 data_in_i_enable;
  logic                 data_in_j_enable;
  logic [DATA_SIZE-1:0] modulo_in;
  logic [DATA_SIZE-1:0] data_in;
  logic                 ready;
  logic                 data_out_i_enable;
  logic                 data_out_j_enable;
  logic [DATA_SIZE-1:0] data_out;

  int                   seed = 18833;
  int unsigned          primes [NUM_PRIMES] = '{3, 5, 7, 13, 17, 101, 257, 1021, 4093,
                                                32749, 65521};
  logic [DATA_SIZE-1:0] expected_q [$];
  logic [DATA_SIZE-1:0] exp_val;
  logic                 started = 1'b0;
  int                   out_count = 0;
  int                   runs_done = 0;
  int                   mismatch_errors = 0;
  int                   frame_errors = 0;
  int                   chk_errors = 0;
  int                   cycle_count = 0;

  ntm_clock_gen #(
    .PERIOD_NS   (100),
    .RESET_CYCLES(4)
  ) i_ntm_clock_gen (
    .CLK(CLK),
    .RST(RST)
  );

  ntm_matrix_inversion #(
    .DATA_SIZE(DATA_SIZE)
  ) i_ntm_matrix_inversion (
    .CLK              (CLK),
    .RST              (RST),
    .START            (start),
    .READY            (ready),
    .DATA_IN_I_ENABLE (data_in_i_enable),
    .DATA_IN_J_ENABLE (data_in_j_enable),
    .DATA_OUT_I_ENABLE(data_out_i_enable),
    .DATA_OUT_J_ENABLE(data_out_j_enable),
    .MODULO_IN        (modulo_in),
    .DATA_IN          (data_in),
    .DATA_OUT         (data_out)
  );

  bind ntm_matrix_inversion ntm_matrix_inversion_chk #(
    .DATA_SIZE(DATA_SIZE)
  ) i_ntm_matrix_inversion_chk (
    .CLK         (CLK),
    .RST         (RST),
    .state       (state_int),
    .start_add   (start_add),
    .ready_add   (ready_add),
    .start_mul   (start_mul),
    .ready_mul   (ready_mul),
    .ready       (READY),
    .out_i_enable(DATA_OUT_I_ENABLE),
    .out_j_enable(DATA_OUT_J_ENABLE)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic matrix_t make_matrix(input int a, input int b, input int c, input int d);
    matrix_t res;
    res[0] = DATA_SIZE'(a);
    res[1] = DATA_SIZE'(b);
    res[2] = DATA_SIZE'(c);
    res[3] = DATA_SIZE'(d);
    return res;
  endfunction

  // det^(m-2) times the adjugate, right to left exponent scan
  function automatic matrix_t inverse_ref(input matrix_t mat, input longint m);
    longint  a, b, c, d, det, inv, base, e;
    matrix_t res;
    a = mat[0];
    b = mat[1];
    c = mat[2];
    d = mat[3];
    det = (a * d - b * c) % m;
    if (det < 0) begin
      det = det + m;
    end
    inv  = 1;
    base = det;
    e    = m - 2;
    while (e > 0) begin
      if (e[0]) begin
        inv = (inv * base) % m;
      end
      base = (base * base) % m;
      e    = e >> 1;
    end
    res[0] = DATA_SIZE'((inv * d) % m);
    res[1] = DATA_SIZE'((inv * ((m - b) % m)) % m);
    res[2] = DATA_SIZE'((inv * ((m - c) % m)) % m);
    res[3] = DATA_SIZE'((inv * a) % m);
    return res;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_edge();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  task automatic release_inputs();
    start            = 1'b0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    data_in          = '0;
  endtask

  task automatic run_matrix(input matrix_t mat, input logic [DATA_SIZE-1:0] m,
                            input matrix_t want);
    int target;
    target = runs_done + 1;
    for (int k = 0; k < ELEMS; k++) begin
      expected_q.push_back(want[k]);
    end
    // Stray load strobe while idle
    drive_edge();
    data_in_j_enable = 1'b1;
    data_in          = ~mat[0];
    drive_edge();
    data_in_j_enable = 1'b0;
    start            = 1'b1;
    modulo_in        = m;
    started          = 1'b1;
    drive_edge();
    start = 1'b0;
    // Row-major load, I on the first element of each row
    for (int k = 0; k < ELEMS; k++) begin
      data_in_i_enable = (k % ORDER) == 0;
      data_in_j_enable = 1'b1;
      data_in          = mat[k];
      drive_edge();
    end
    // START, strobes and modulus during the computation
    start            = 1'b1;
    data_in_i_enable = 1'b1;
    data_in_j_enable = 1'b1;
    data_in          = DATA_SIZE'($random(seed));
    modulo_in        = DATA_SIZE'($random(seed));
    drive_edge();
    release_inputs();
    while (runs_done < target) begin
      @(posedge CLK);
    end
  endtask

  initial begin
    matrix_t              mat;
    logic [DATA_SIZE-1:0] m;
    release_inputs();
    modulo_in = '0;
    wait (RST === 1'b0);
    repeat (3) @(posedge CLK);

    // Directed, modulo 17
    run_matrix(make_matrix(1, 0, 0, 1), 17, make_matrix(1, 0, 0, 1));
    run_matrix(make_matrix(2, 1, 1, 1), 17, make_matrix(1, 16, 16, 2));
    run_matrix(make_matrix(1, 2, 3, 4), 17, make_matrix(15, 1, 10, 8));
    run_matrix(make_matrix(16, 0, 0, 16), 17, make_matrix(16, 0, 0, 16));
    // Singular, rows are multiples
    run_matrix(make_matrix(2, 4, 1, 2), 17, make_matrix(0, 0, 0, 0));
    run_matrix(make_matrix(5, 10, 3, 6), 17, make_matrix(0, 0, 0, 0));

    // Random residues below a random prime
    for (int n = 0; n < NUM_RANDOM; n++) begin
      m = DATA_SIZE'(primes[$unsigned($random(seed)) % NUM_PRIMES]);
      for (int k = 0; k < ELEMS; k++) begin
        mat[k] = DATA_SIZE'($unsigned($random(seed)) % m);
      end
      run_matrix(mat, m, inverse_ref(mat, m));
    end

    repeat (5) @(posedge CLK);
    assert (runs_done == NUM_DIRECTED + NUM_RANDOM && expected_q.size() == 0) else begin
      $display("%0d runs finished, %0d results never arrived", runs_done, expected_q.size());
      frame_errors++;
    end
    chk_errors = i_ntm_matrix_inversion.i_ntm_matrix_inversion_chk.fail_count;
    $display("errors: %0d mismatch, %0d framing, %0d checker",
             mismatch_errors, frame_errors, chk_errors);
    if (mismatch_errors + frame_errors + chk_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Comparison, sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      // Quiet outputs until the first START
      if (!started) begin
        assert (!ready && !data_out_i_enable && !data_out_j_enable && data_out == '0) else begin
          $display("outputs active after reset before any START at %0t ns", $time);
          frame_errors++;
        end
      end
      if (data_out_j_enable) begin
        if (expected_q.size() == 0) begin
          $display("output strobe at %0t ns with no result pending", $time);
          frame_errors++;
        end else begin
          exp_val = expected_q.pop_front();
          assert (data_out == exp_val) else begin
            $display("mismatch at %0t ns: element %0d is %0d, expected %0d",
                     $time, out_count, data_out, exp_val);
            mismatch_errors++;
          end
        end
        assert (data_out_i_enable == ((out_count % ORDER) == 0)) else begin
          $display("row strobe wrong on output element %0d at %0t ns", out_count, $time);
          frame_errors++;
        end
        out_count++;
      end
      if (ready) begin
        assert (out_count == ELEMS) else begin
          $display("READY after %0d output strobes at %0t ns", out_count, $time);
          frame_errors++;
        end
        out_count = 0;
        runs_done++;
      end
    end
  end

  // Run limit
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the DUT did not finish all matrices", cycle_count);
    chk_errors = i_ntm_matrix_inversion.i_ntm_matrix_inversion_chk.fail_count;
    $display("errors: %0d mismatch, %0d framing, %0d checker",
             mismatch_errors, frame_errors, chk_errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* ntm_matrix_inversion.f */
+incdir+include
verilog/ntm_math_pkg.sv
verilog/ntm_ctrl_pkg.sv
verilog/ntm_scalar_adder.sv
verilog/ntm_scalar_multiplier.sv
verilog/ntm_matrix_inversion.sv
testbench/ntm_clock_gen.sv
testbench/ntm_matrix_inversion_chk.sv
testbench/ntm_matrix_inversion_tb.sv
